// ==== motor_cfg_pkg.sv ====
package motor_cfg_pkg;

	// axis and slot counts
	localparam int MOTOR_NBR = 2;
	localparam int SLOT_NBR = 8;	// one tick per axis every 8 clocks

	// speed table geometry
	localparam int TBL_DEPTH = 64;
	localparam int TBL_AW = $clog2(TBL_DEPTH);

	// index into the speed table
	typedef logic [TBL_AW-1:0] tbl_addr_t;

	// loaded entry count up to a full table
	typedef logic [TBL_AW:0] tbl_len_t;

	// step period in slot ticks with a legal minimum of 2
	typedef logic [15:0] period_t;

	// steps of one move
	typedef logic [15:0] step_cnt_t;

endpackage

// ==== motor_state_pkg.sv ====
package motor_state_pkg;

	// ramp FSM states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FETCH,	// waiting for the table entry of the next step
		ST_ACCEL,
		ST_CRUISE,
		ST_DECEL
	} motion_state_t;

endpackage

// ==== speed_table_ram.sv ====
`timescale 1ns/1ps

module speed_table_ram
	import motor_cfg_pkg::*;
(
	input  logic      clk,
	input  logic      resetn,
	input  logic      i_load,
	input  logic      i_wr,
	input  period_t   i_wr_data,
	input  tbl_addr_t i_rd_addr,
	output period_t   o_rd_data,
	output tbl_len_t  o_len
);

	period_t mem [TBL_DEPTH];
	tbl_addr_t wr_ptr;
	tbl_len_t len;
	logic load_q;
	logic load_rise;
	logic wr_en;

	assign load_rise = i_load & ~load_q;
	assign wr_en = i_load & i_wr & ~load_rise & (len != tbl_len_t'(TBL_DEPTH));	// full table drops writes
	assign o_len = len;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			load_q <= 1'b0;
			wr_ptr <= '0;
			len <= '0;
		end else begin
			load_q <= i_load;
			if (load_rise) begin	// new load restarts the list
				wr_ptr <= '0;
				len <= '0;
			end else if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
				len <= len + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= i_wr_data;
		o_rd_data <= mem[i_rd_addr];	// one cycle read latency
	end

endmodule

// ==== slot_sequencer.sv ====
`timescale 1ns/1ps

module slot_sequencer
	import motor_cfg_pkg::*;
(
	input  logic                           clk,
	input  logic                           resetn,
	input  tbl_addr_t [MOTOR_NBR-1:0]      i_addr,
	output logic      [MOTOR_NBR-1:0]      o_slot_tick,
	output logic      [MOTOR_NBR-1:0]      o_data_vld,
	output tbl_addr_t                      o_rd_addr
);

	logic [SLOT_NBR-1:0] ring;
	logic [MOTOR_NBR-1:0] vld_d1;
	logic [MOTOR_NBR-1:0] vld_d2;
	tbl_addr_t addr_sel;

	assign o_slot_tick = ring[MOTOR_NBR-1:0];	// slot n belongs to axis n
	assign o_data_vld = vld_d2;

	// rotating one-hot slot ring
	always_ff @(posedge clk) begin
		if (!resetn)
			ring <= SLOT_NBR'(1);
		else
			ring <= {ring[SLOT_NBR-2:0], ring[SLOT_NBR-1]};
	end

	// only the ticking axis contributes its index
	always_comb begin
		addr_sel = '0;
		for (int n = 0; n < MOTOR_NBR; n++) begin
			addr_sel = addr_sel | (i_addr[n] & {$bits(tbl_addr_t){ring[n]}});
		end
	end

	always_ff @(posedge clk) begin
		o_rd_addr <= addr_sel;	// shared read address
	end

	// tick delayed by address register plus ram read
	always_ff @(posedge clk) begin
		if (!resetn) begin
			vld_d1 <= '0;
			vld_d2 <= '0;
		end else begin
			vld_d1 <= ring[MOTOR_NBR-1:0];
			vld_d2 <= vld_d1;
		end
	end

endmodule

// ==== step_pulse_timer.sv ====
`timescale 1ns/1ps

module step_pulse_timer
	import motor_cfg_pkg::*;
(
	input  logic    clk,
	input  logic    resetn,
	input  logic    i_tick,
	input  logic    i_load,
	input  period_t i_period,
	output logic    o_expire
);

	period_t cnt;

	// down-counter in slot ticks
	always_ff @(posedge clk) begin
		if (!resetn)
			cnt <= '0;
		else if (i_load)
			cnt <= i_period;
		else if (i_tick && cnt != '0)
			cnt <= cnt - 1'b1;
	end

	// strobe on the tick that takes it to zero
	assign o_expire = i_tick & ~i_load & (cnt == period_t'(1));

endmodule

// ==== step_ramp_fsm.sv ====
`timescale 1ns/1ps

module step_ramp_fsm
	import motor_cfg_pkg::*;
	import motor_state_pkg::*;
(
	input  logic      clk,
	input  logic      resetn,
	input  logic      i_start,
	input  logic      i_stop,
	input  logic      i_dir,
	input  step_cnt_t i_steps,
	input  period_t   i_target,
	input  logic      i_tick,
	input  logic      i_data_vld,
	input  period_t   i_rd_data,
	input  tbl_len_t  i_len,
	input  logic      i_expire,
	output tbl_addr_t o_addr,
	output logic      o_tmr_load,
	output period_t   o_tmr_period,
	output logic      o_drive,
	output logic      o_dir,
	output logic      o_busy,
	output period_t   o_rt_speed
);

	motion_state_t state;
	motion_state_t phase;	// ramp phase of the step being fetched
	motion_state_t phase_nxt;
	step_cnt_t steps_q;
	step_cnt_t k;	// current step number
	step_cnt_t left;
	step_cnt_t lim;
	period_t target_q;
	period_t rt_speed;
	tbl_addr_t idx;
	tbl_addr_t cap;
	tbl_addr_t idx_nxt;
	logic cap_found;
	logic stopping;
	logic fetch_req;
	logic start_ok;
	logic accept;
	logic cap_hit;
	logic last_step;
	logic advance;

	assign o_addr = idx;
	assign o_tmr_period = rt_speed;
	assign o_rt_speed = rt_speed;

	assign left = steps_q - k - step_cnt_t'(1);	// steps after this one
	assign start_ok = (state == ST_IDLE) && i_start && (i_steps != '0) && (i_len != '0);
	assign accept = (state == ST_FETCH) && fetch_req && i_data_vld;
	assign cap_hit = accept && !cap_found && ((i_rd_data <= target_q) || (idx == cap));
	assign last_step = (left == '0) || (stopping && idx == '0);
	assign advance = (state == ST_ACCEL || state == ST_CRUISE || state == ST_DECEL) &&
		i_expire && !last_step;

	// next index is min(k+1, S-2-k, cap) or one down when stopping
	always_comb begin
		lim = k + step_cnt_t'(1);
		if (left - step_cnt_t'(1) < lim)
			lim = left - step_cnt_t'(1);
		if (step_cnt_t'(cap) < lim)
			lim = step_cnt_t'(cap);
		if (stopping)
			idx_nxt = idx - 1'b1;
		else
			idx_nxt = tbl_addr_t'(lim);
		if (idx_nxt > idx)
			phase_nxt = ST_ACCEL;
		else if (idx_nxt == idx)
			phase_nxt = ST_CRUISE;
		else
			phase_nxt = ST_DECEL;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= ST_IDLE;
			phase <= ST_IDLE;
			idx <= '0;
			cap_found <= 1'b0;
			stopping <= 1'b0;
			fetch_req <= 1'b0;
			o_tmr_load <= 1'b0;
			o_drive <= 1'b0;
			o_dir <= 1'b0;
			o_busy <= 1'b0;
			rt_speed <= '0;
		end else begin
			o_tmr_load <= 1'b0;
			if (accept)
				o_drive <= 1'b1;
			else if (i_data_vld)
				o_drive <= 1'b0;	// pulse lasts one slot period
			if (i_stop && state != ST_IDLE)
				stopping <= 1'b1;
			if (cap_hit)
				cap_found <= 1'b1;
			case (state)
				ST_IDLE: begin
					if (start_ok) begin
						state <= ST_FETCH;
						phase <= ST_ACCEL;
						o_busy <= 1'b1;
						o_dir <= i_dir;
						idx <= '0;
						cap_found <= 1'b0;
						stopping <= 1'b0;
						fetch_req <= 1'b0;
					end
				end
				ST_FETCH: begin
					if (i_tick)
						fetch_req <= 1'b1;	// address goes out on this tick
					if (accept) begin
						state <= phase;
						fetch_req <= 1'b0;
						rt_speed <= i_rd_data;
						o_tmr_load <= 1'b1;
					end
				end
				ST_ACCEL, ST_CRUISE, ST_DECEL: begin
					if (i_expire && last_step) begin
						state <= ST_IDLE;
						o_busy <= 1'b0;
					end else if (advance) begin
						state <= ST_FETCH;
						phase <= phase_nxt;
						idx <= idx_nxt;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// move parameters and counters
	always_ff @(posedge clk) begin
		if (start_ok) begin
			steps_q <= i_steps;
			target_q <= i_target;
			k <= '0;
			cap <= tbl_addr_t'(i_len - 1'b1);	// last entry until target is met
		end else begin
			if (advance)
				k <= k + step_cnt_t'(1);
			if (cap_hit)
				cap <= idx;
		end
	end

endmodule

// ==== step_motor_ctrl.sv ====
`timescale 1ns/1ps

module step_motor_ctrl
	import motor_cfg_pkg::*;
(
	input  logic                           clk,
	input  logic                           resetn,
	input  logic                           i_tbl_load,
	input  logic                           i_tbl_wr,
	input  period_t                        i_tbl_data,
	output tbl_len_t                       o_tbl_len,
	input  logic      [MOTOR_NBR-1:0]      i_start,
	input  logic      [MOTOR_NBR-1:0]      i_stop,
	input  logic      [MOTOR_NBR-1:0]      i_dir,
	input  step_cnt_t [MOTOR_NBR-1:0]      i_steps,
	input  period_t   [MOTOR_NBR-1:0]      i_target,
	output logic      [MOTOR_NBR-1:0]      o_drive,
	output logic      [MOTOR_NBR-1:0]      o_dir,
	output logic      [MOTOR_NBR-1:0]      o_busy,
	output period_t   [MOTOR_NBR-1:0]      o_rt_speed
);

	tbl_addr_t [MOTOR_NBR-1:0] tbl_addr;
	logic [MOTOR_NBR-1:0] slot_tick;
	logic [MOTOR_NBR-1:0] data_vld;
	logic [MOTOR_NBR-1:0] tmr_load;
	logic [MOTOR_NBR-1:0] tmr_expire;
	period_t [MOTOR_NBR-1:0] tmr_period;
	tbl_addr_t rd_addr;
	period_t rd_data;

	speed_table_ram u_speed_table_ram (
		.clk       (clk),
		.resetn    (resetn),
		.i_load    (i_tbl_load),
		.i_wr      (i_tbl_wr),
		.i_wr_data (i_tbl_data),
		.i_rd_addr (rd_addr),
		.o_rd_data (rd_data),
		.o_len     (o_tbl_len)
	);

	slot_sequencer u_slot_sequencer (
		.clk         (clk),
		.resetn      (resetn),
		.i_addr      (tbl_addr),
		.o_slot_tick (slot_tick),
		.o_data_vld  (data_vld),
		.o_rd_addr   (rd_addr)
	);

	for (genvar n = 0; n < MOTOR_NBR; n++) begin : g_axis
		step_ramp_fsm u_step_ramp_fsm (
			.clk          (clk),
			.resetn       (resetn),
			.i_start      (i_start[n]),
			.i_stop       (i_stop[n]),
			.i_dir        (i_dir[n]),
			.i_steps      (i_steps[n]),
			.i_target     (i_target[n]),
			.i_tick       (slot_tick[n]),
			.i_data_vld   (data_vld[n]),
			.i_rd_data    (rd_data),	// shared bus valid on this axis' strobe
			.i_len        (o_tbl_len),
			.i_expire     (tmr_expire[n]),
			.o_addr       (tbl_addr[n]),
			.o_tmr_load   (tmr_load[n]),
			.o_tmr_period (tmr_period[n]),
			.o_drive      (o_drive[n]),
			.o_dir        (o_dir[n]),
			.o_busy       (o_busy[n]),
			.o_rt_speed   (o_rt_speed[n])
		);

		step_pulse_timer u_step_pulse_timer (
			.clk      (clk),
			.resetn   (resetn),
			.i_tick   (slot_tick[n]),
			.i_load   (tmr_load[n]),
			.i_period (tmr_period[n]),
			.o_expire (tmr_expire[n])
		);
	end

endmodule

// ==== step_motor_sva.sv ====
`timescale 1ns/1ps

module step_motor_sva
	import motor_cfg_pkg::*;
	import motor_state_pkg::*;
(
	input logic                 clk,
	input logic                 resetn,
	input logic [MOTOR_NBR-1:0] o_drive,
	input logic [MOTOR_NBR-1:0] o_dir,
	input logic [MOTOR_NBR-1:0] o_busy
);

	// busy clear right after reset
	a_busy_reset: assert property (@(posedge clk) !resetn |=> o_busy == '0)
		else $error("o_busy set after reset");

	for (genvar n = 0; n < MOTOR_NBR; n++) begin : g_axis
		a_drive_busy: assert property (@(posedge clk) disable iff (!resetn)
			o_drive[n] |-> o_busy[n])
			else $error("o_drive high while idle on axis %0d", n);

		a_dir_stable: assert property (@(posedge clk) disable iff (!resetn)
			(o_busy[n] && $past(o_busy[n])) |-> $stable(o_dir[n]))
			else $error("o_dir changed during a move on axis %0d", n);

		// pulse was high for the last SLOT_NBR cycles and low before
		a_drive_width: assert property (@(posedge clk) disable iff (!resetn)
			$fell(o_drive[n]) |-> ($past(o_drive[n], SLOT_NBR) &&
			!$past(o_drive[n], SLOT_NBR + 1)))
			else $error("o_drive pulse width wrong on axis %0d", n);
	end

endmodule

bind step_motor_ctrl step_motor_sva u_step_motor_sva (
	.clk     (clk),
	.resetn  (resetn),
	.o_drive (o_drive),
	.o_dir   (o_dir),
	.o_busy  (o_busy)
);

// ==== tb_step_motor.sv ====
`timescale 1ns/1ps

module tb_step_motor
	import motor_cfg_pkg::*;
();

	localparam int N_ROWS = 5;
	localparam int N_TBL = 20;
	localparam int N_OVERFILL = 70;

	// one row per move with axis, direction, steps, target, stop after step (0 = none) and wait
	int row_axis   [N_ROWS] = '{0, 1, 0, 0, 1};
	int row_dir    [N_ROWS] = '{1, 0, 0, 1, 1};
	int row_steps  [N_ROWS] = '{30, 6, 40, 12, 25};
	int row_target [N_ROWS] = '{20, 4, 10, 30, 6};
	int row_stop   [N_ROWS] = '{0, 0, 14, 0, 0};
	int row_wait   [N_ROWS] = '{1, 1, 1, 0, 1};	// row 3 overlaps row 4

	logic clk;
	logic resetn;
	logic tbl_load;
	logic tbl_wr;
	period_t tbl_data;
	tbl_len_t tbl_len;
	logic [MOTOR_NBR-1:0] start;
	logic [MOTOR_NBR-1:0] stop;
	logic [MOTOR_NBR-1:0] dir;
	step_cnt_t [MOTOR_NBR-1:0] steps;
	period_t [MOTOR_NBR-1:0] target;
	logic [MOTOR_NBR-1:0] drive;
	logic [MOTOR_NBR-1:0] dir_out;
	logic [MOTOR_NBR-1:0] busy;
	period_t [MOTOR_NBR-1:0] rt_speed;

	period_t tbl [TBL_DEPTH];
	period_t exp_q [MOTOR_NBR][$];	// expected speed per step
	logic exp_dir [MOTOR_NBR];
	int exp_total [MOTOR_NBR];
	int stop_at [MOTOR_NBR];
	int rises [MOTOR_NBR];
	logic [MOTOR_NBR-1:0] drive_q;
	logic [MOTOR_NBR-1:0] busy_q;
	int val_errs;
	int other_errs;
	int cycles;
	int cycle_limit;
	logic [31:0] rng;

	step_motor_ctrl u_step_motor_ctrl (
		.clk        (clk),
		.resetn     (resetn),
		.i_tbl_load (tbl_load),
		.i_tbl_wr   (tbl_wr),
		.i_tbl_data (tbl_data),
		.o_tbl_len  (tbl_len),
		.i_start    (start),
		.i_stop     (stop),
		.i_dir      (dir),
		.i_steps    (steps),
		.i_target   (target),
		.o_drive    (drive),
		.o_dir      (dir_out),
		.o_busy     (busy),
		.o_rt_speed (rt_speed)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (exp === got) else begin
			$display("ERR %s exp=%h got=%h", name, exp, got);
			val_errs++;
		end
	endtask

	// lowest index at or below the target period
	function automatic int find_cap(input int tgt);
		for (int i = 0; i < N_TBL; i++) begin
			if (int'(tbl[i]) <= tgt)
				return i;
		end
		return N_TBL - 1;
	endfunction

	function automatic int ramp_index(input int k, input int s, input int cap);
		int m;
		m = k;
		if (s - 1 - k < m)
			m = s - 1 - k;
		if (cap < m)
			m = cap;
		return m;
	endfunction

	// expected step speeds of one row
	task automatic plan_move(input int r);
		int a;
		int s;
		int cap;
		int p;
		int j;
		int total;
		int idx;
		a = row_axis[r];
		s = row_steps[r];
		p = row_stop[r];
		cap = find_cap(row_target[r]);
		total = s;
		j = 0;
		if (p > 0) begin
			j = ramp_index(p - 1, s, cap);
			if (p + j < total)
				total = p + j;
		end
		exp_q[a].delete();
		for (int k = 0; k < total; k++) begin
			if (p > 0 && k >= p)
				idx = j - (k - p + 1);	// stop ramps down one entry per step
			else
				idx = ramp_index(k, s, cap);
			exp_q[a].push_back(tbl[idx]);
		end
		exp_dir[a] = (row_dir[r] != 0);
		exp_total[a] = total;
		stop_at[a] = p;
		rises[a] = 0;
	endtask

	// step pulse monitor that also issues stop requests
	always @(negedge clk) begin
		for (int a = 0; a < MOTOR_NBR; a++) begin
			stop[a] = 1'b0;
			if (resetn && drive[a] && !drive_q[a]) begin
				rises[a]++;
				assert (exp_q[a].size() != 0) else begin
					$display("unexpected step pulse on axis %0d", a);
					other_errs++;
				end
				if (exp_q[a].size() != 0) begin
					check_val($sformatf("o_rt_speed[%0d]", a), 32'(exp_q[a].pop_front()),
						32'(rt_speed[a]));
					check_val($sformatf("o_dir[%0d]", a), 32'(exp_dir[a]), 32'(dir_out[a]));
				end
				if (stop_at[a] != 0 && rises[a] == stop_at[a])
					stop[a] = 1'b1;
			end
			if (resetn && busy_q[a] && !busy[a])
				check_val($sformatf("step count[%0d]", a), 32'(exp_total[a]), 32'(rises[a]));
		end
		drive_q = drive;
		busy_q = busy;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: moves did not finish within %0d cycles", cycle_limit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	initial begin
		int maxp;
		int a;
		resetn = 1'b0;
		tbl_load = 1'b0;
		tbl_wr = 1'b0;
		tbl_data = '0;
		start = '0;
		stop = '0;
		dir = '0;
		steps = '0;
		target = '0;
		drive_q = '0;
		busy_q = '0;
		val_errs = 0;
		other_errs = 0;
		cycles = 0;
		rng = 32'd22227;
		for (int i = 0; i < N_TBL; i++) begin	// descending series jittered by one
			rng = xorshift(rng);
			tbl[i] = period_t'(40 - 2 * i + int'(rng[0]));
		end
		maxp = 0;
		for (int i = 0; i < N_TBL; i++)
			if (int'(tbl[i]) > maxp)
				maxp = int'(tbl[i]);
		cycle_limit = 16 + 2 * (N_OVERFILL + N_TBL) + 100;	// reset and loads
		for (int r = 0; r < N_ROWS; r++)
			cycle_limit += row_steps[r] * (maxp + 1) * SLOT_NBR + 64;

		repeat (16) @(negedge clk);
		resetn = 1'b1;
		@(negedge clk);
		check_val("o_drive", 32'd0, 32'(drive));
		check_val("o_busy", 32'd0, 32'(busy));
		check_val("o_rt_speed", 32'd0, 32'(rt_speed));
		check_val("o_tbl_len", 32'd0, 32'(tbl_len));

		// overfill saturates the length at the depth
		tbl_load = 1'b1;
		@(negedge clk);
		for (int i = 0; i < N_OVERFILL; i++) begin
			tbl_wr = 1'b1;
			tbl_data = period_t'(i + 2);
			@(negedge clk);
		end
		tbl_wr = 1'b0;
		check_val("o_tbl_len", 32'(TBL_DEPTH), 32'(tbl_len));
		tbl_load = 1'b0;
		@(negedge clk);

		tbl_load = 1'b1;
		@(negedge clk);
		for (int i = 0; i < N_TBL; i++) begin
			tbl_wr = 1'b1;
			tbl_data = tbl[i];
			@(negedge clk);
		end
		tbl_wr = 1'b0;
		check_val("o_tbl_len", 32'(N_TBL), 32'(tbl_len));
		tbl_load = 1'b0;
		@(negedge clk);

		for (int r = 0; r < N_ROWS; r++) begin
			a = row_axis[r];
			while (busy[a])
				@(negedge clk);
			@(negedge clk);	// monitor closes the previous move first
			plan_move(r);
			dir[a] = (row_dir[r] != 0);
			steps[a] = step_cnt_t'(row_steps[r]);
			target[a] = period_t'(row_target[r]);
			start[a] = 1'b1;
			@(negedge clk);
			start[a] = 1'b0;
			check_val($sformatf("o_busy[%0d]", a), 32'd1, 32'(busy[a]));
			if (row_wait[r] != 0)
				while (busy != '0)
					@(negedge clk);
		end
		while (busy != '0)
			@(negedge clk);
		repeat (4) @(negedge clk);

		$display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
		if (val_errs + other_errs == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== compile.f ====
motor_cfg_pkg.sv
motor_state_pkg.sv
speed_table_ram.sv
slot_sequencer.sv
step_pulse_timer.sv
step_ramp_fsm.sv
step_motor_ctrl.sv
step_motor_sva.sv
tb_step_motor.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_step_motor -f compile.f

out=$(./obj_dir/Vtb_step_motor)
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
	exit 0
fi
exit 1
